// ==== project.f ====
+incdir+design
design/fetchPkg.sv
design/preDecode.sv
design/ctiQueue.sv
design/fetchStage2.sv
design/bundleLatch.sv
design/fetchStage2Top.sv
testbench/fetchStage2Tb.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the fetch stage 2 testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal -f project.f \
  --top-module fetchStage2Tb -o simv

# the testbench stops with a failing status on an error, the log decides
./obj_dir/simv > sim.log 2>&1 || true

if grep -q "TEST PASSED" sim.log; then
  echo "simulation passed, see sim.log"
  exit 0
else
  echo "simulation failed, see sim.log"
  exit 1
fi

// ==== testbench/stage2_input.txt ====
# bundle pc i0 i1 i2 i3 hit pred btbT ras | mask rec target call ret callPc tags
# resolve tag target taken | commit pc target type taken | ready mode | status inReady | idle n
bundle 1000 00000000 40000010 00000000 00000000 2 2 1044 0 3 0 0 0 0 0 240
bundle 3000 00000000 00000000 44000020 00000000 0 0 0 0 7 1 3088 0 0 0 449
bundle 4000 4c000000 00000000 00000000 00000000 0 0 0 5550 1 1 5550 0 1 0 6da
# resolve out of order, then commit oldest first
resolve 2 5550 1
resolve 0 1044 0
resolve 1 3088 1
commit 1004 1044 3 0
commit 3008 3088 2 1
commit 4000 5550 0 1
bundle 6000 00000000 48000100 00000000 00000000 0 0 0 0 3 1 6404 1 0 6004 91b
bundle 7000 44000004 00000000 00000000 00000000 1 0 7010 0 1 0 0 0 0 0 b6c
# decode stalls, the latch must hold its bundle
ready 0
bundle 8000 00000000 00000000 00000000 00000000 0 0 0 0 f 0 0 0 0 0 b6d
status 0
idle 3
ready 1
bundle 2000 40000008 40000008 40000008 40000008 0 0 0 0 f 0 0 0 0 0 1f5
status 0
drain
flush
status 1
bundle 9000 40000008 00000000 00000000 00000000 1 1 9020 0 1 0 0 0 0 0 923
ready 2
bundle a000 00000000 00000000 00000000 00000000 0 0 0 0 f 0 0 0 0 0 924
bundle b000 00000000 00000000 00000000 00000000 0 0 0 0 f 0 0 0 0 0 924
bundle c000 44000004 00000000 00000000 00000000 1 0 c010 0 1 0 0 0 0 0 b6c
drain
ready 1
resolve 4 c010 1
resolve 3 9020 0
commit 9000 9020 3 0
commit c000 c010 2 1

// ==== testbench/fetchStage2Tb.sv ====
/*
  vector-driven testbench for fetchStage2Top with vectors read from testbench/stage2_input.txt
  the file holds one record per line and no blank lines so that reported line numbers match
  expected values in the file were worked out by hand from the stage rules
*/
`timescale 1ns/1ps
`default_nettype none
`include "fetch_consts.svh"

module fetchStage2Tb;

  logic clk, reset_i, flush_i, inValid_i, outReady_i;
  logic [`SIZE_PC-1:0] pc_i, rasTarget_i, resolveTarget_i;
  logic [`FETCH_WIDTH-1:0][`SIZE_INSTRUCTION-1:0] bundle_i;
  logic [`FETCH_WIDTH-1:0] btbHit_i, prediction_i;
  logic [`FETCH_WIDTH-1:0][`SIZE_PC-1:0] btbTarget_i;
  logic inReady_o, recoverId_o, returnId_o, callId_o, outValid_o;
  logic [`SIZE_PC-1:0] targetId_o, callPcId_o;
  logic [`FETCH_WIDTH-1:0] slotValid_o, slotPred_o;
  logic [`FETCH_WIDTH-1:0][`SIZE_INSTRUCTION-1:0] slotInstr_o;
  logic [`FETCH_WIDTH-1:0][`SIZE_PC-1:0] slotPc_o, slotTarget_o;
  logic [`FETCH_WIDTH-1:0][`SIZE_CTI_LOG-1:0] slotTag_o;
  logic resolveValid_i, resolveTaken_i, commitValid_i;
  logic [`SIZE_CTI_LOG-1:0] resolveTag_i;
  logic updateEn_o, updateTaken_o;
  logic [`SIZE_PC-1:0] updatePc_o, updateTarget_o;
  fetchPkg::ctrlType_t updateCtrlType_o;

  integer fd, code, lineNo, cnt;
  integer seed = 32'h1824;
  reg [8*16-1:0] kind;
  reg [8*256-1:0] rest;
  logic [31:0] f [0:15];
  logic [1:0] readyMode;
  logic [31:0] expQ [$];
  logic held;
  logic [`FETCH_WIDTH-1:0] heldValid;
  logic [`FETCH_WIDTH-1:0][`SIZE_PC-1:0] heldPc;
  logic [`FETCH_WIDTH-1:0][`SIZE_CTI_LOG-1:0] heldTag;

  fetchStage2Top dut (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic checkValue(input string name,
                            input logic [`FETCH_WIDTH*`SIZE_PC-1:0] expected,
                            input logic [`FETCH_WIDTH*`SIZE_PC-1:0] actual);
    if (expected !== actual) begin
      $display("Fail %s: expected %h, actual %h", name, expected, actual);
      $display("TEST FAILED");
      $fatal(1, "mismatch in %s", name);
    end
  endtask

  task automatic stopOnTimeout(input string what);
    $display("timeout at line %0d: %s", lineNo, what);
    $display("TEST FAILED");
    $fatal(1, "timeout");
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // decode side with random ready and an in-order delivery check
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always @(posedge clk) begin
    #1;
    if (readyMode == 2'd2) outReady_i = $random(seed);
  end

  always @(negedge clk) begin
    if (!reset_i) begin
      if (held && outValid_o) begin
        checkValue("held slot valid", heldValid, slotValid_o);
        checkValue("held slot pc", heldPc, slotPc_o);
        checkValue("held slot tag", heldTag, slotTag_o);
      end
      held      = outValid_o && !outReady_i;
      heldValid = slotValid_o;
      heldPc    = slotPc_o;
      heldTag   = slotTag_o;
      if (outValid_o && outReady_i) begin
        if (expQ.size() == 0) begin
          $display("decode received a bundle that was never sent");
          $display("TEST FAILED");
          $fatal(1, "extra bundle");
        end else begin
          checkValue("delivered bundle pc", expQ.pop_front(), slotPc_o[0]);
        end
      end
    end
  end

  // kept slots carry their own pc and instruction, control slots also
  // their target and predicted direction
  task automatic checkPacket(input string t);
    logic [`SIZE_INSTRUCTION-1:0] instr;
    logic [5:0]                   op;
    logic [`SIZE_PC-1:0]          pcExp;
    logic [`SIZE_PC-1:0]          targetExp;
    logic                         isCtrlOp;
    int                           offset;
    for (int s = 0; s < `FETCH_WIDTH; s++) begin
      instr    = f[s + 1];
      op       = instr[31:26];
      pcExp    = f[0] + s * `INST_BYTES;
      isCtrlOp = (op == fetchPkg::OP_BRANCH) || (op == fetchPkg::OP_JUMP) ||
                 (op == fetchPkg::OP_CALL) || (op == fetchPkg::OP_RETURN);
      if (f[9][s]) begin
        checkValue($sformatf("%s slot %0d pc", t, s), pcExp, slotPc_o[s]);
        checkValue($sformatf("%s slot %0d instr", t, s), instr, slotInstr_o[s]);
      end
      if (f[9][s] && isCtrlOp) begin
        offset = $signed(instr[15:0]);
        if (f[5][s]) begin
          targetExp = f[7];
        end else if (op == fetchPkg::OP_RETURN) begin
          targetExp = f[8];
        end else begin
          targetExp = pcExp + offset * 4;
        end
        checkValue($sformatf("%s slot %0d target", t, s), targetExp, slotTarget_o[s]);
        checkValue($sformatf("%s slot %0d pred", t, s),
                   (op != fetchPkg::OP_BRANCH) || f[6][s], slotPred_o[s]);
      end
    end
  endtask

  task automatic sendBundle();
    string t;
    t = $sformatf("line %0d", lineNo);
    @(posedge clk);
    #1;
    pc_i        = f[0];
    bundle_i    = {f[4], f[3], f[2], f[1]};
    btbHit_i    = f[5][`FETCH_WIDTH-1:0];
    prediction_i = f[6][`FETCH_WIDTH-1:0];
    btbTarget_i = {4{f[7]}};
    rasTarget_i = f[8];
    inValid_i   = 1'b1;
    #1;
    cnt = 0;
    while (!inReady_o) begin
      @(posedge clk);
      #2;
      cnt = cnt + 1;
      if (cnt > 100) stopOnTimeout("inReady_o never rose for the bundle");
    end
    checkValue({t, " recover"}, f[10], recoverId_o);
    checkValue({t, " call"}, f[12], callId_o);
    checkValue({t, " return"}, f[13], returnId_o);
    if (f[10][0]) checkValue({t, " redirect target"}, f[11], targetId_o);
    if (f[12][0]) checkValue({t, " call pc"}, f[14], callPcId_o);
    @(posedge clk);
    #1;
    inValid_i = 1'b0;
    expQ.push_back(f[0]);
    #1;
    // the bundle must be at decode one cycle after the accepting edge
    checkValue({t, " latency valid"}, 1, outValid_o);
    checkValue({t, " slot mask"}, f[9], slotValid_o);
    checkValue({t, " slot tags"}, f[15], slotTag_o);
    checkPacket(t);
  endtask

  task automatic drainDecode();
    cnt = 0;
    while (expQ.size() != 0) begin
      @(posedge clk);
      cnt = cnt + 1;
      if (cnt > 200) stopOnTimeout("bundles never drained to decode");
    end
  endtask

  initial begin
    reset_i         = 1'b1;
    flush_i         = 1'b0;
    inValid_i       = 1'b0;
    outReady_i      = 1'b1;
    pc_i            = '0;
    bundle_i        = '0;
    btbHit_i        = '0;
    prediction_i    = '0;
    btbTarget_i     = '0;
    rasTarget_i     = '0;
    resolveValid_i  = 1'b0;
    resolveTag_i    = '0;
    resolveTarget_i = '0;
    resolveTaken_i  = 1'b0;
    commitValid_i   = 1'b0;
    readyMode       = 2'd1;
    held            = 1'b0;
    lineNo          = 0;
    repeat (4) @(posedge clk);
    #1;
    reset_i = 1'b0;
    #1;
    checkValue("reset outValid", 0, outValid_o);
    checkValue("reset updateEn", 0, updateEn_o);
    checkValue("reset recover", 0, recoverId_o);
    checkValue("reset inReady", 1, inReady_o);

    fd = $fopen("testbench/stage2_input.txt", "r");
    if (fd == 0) begin
      $display("could not open testbench/stage2_input.txt");
      $display("TEST FAILED");
      $fatal(1, "no vector file");
    end
    while (!$feof(fd)) begin
      code = $fscanf(fd, "%s", kind);
      if (code == 1) begin
        lineNo = lineNo + 1;
        if (kind == "#") begin
          code = $fgets(rest, fd);
        end else if (kind == "bundle") begin
          for (int k = 0; k < 16; k++) code = $fscanf(fd, "%h", f[k]);
          sendBundle();
        end else if (kind == "resolve") begin
          code = $fscanf(fd, "%h %h %h", f[0], f[1], f[2]);
          @(posedge clk);
          #1;
          resolveValid_i  = 1'b1;
          resolveTag_i    = f[0][`SIZE_CTI_LOG-1:0];
          resolveTarget_i = f[1];
          resolveTaken_i  = f[2][0];
          @(posedge clk);
          #1;
          resolveValid_i = 1'b0;
        end else if (kind == "commit") begin
          code = $fscanf(fd, "%h %h %h %h", f[0], f[1], f[2], f[3]);
          @(posedge clk);
          #1;
          commitValid_i = 1'b1;
          @(posedge clk);
          #1;
          commitValid_i = 1'b0;
          #1;
          checkValue($sformatf("line %0d update enable", lineNo), 1, updateEn_o);
          checkValue($sformatf("line %0d update pc", lineNo), f[0], updatePc_o);
          checkValue($sformatf("line %0d update target", lineNo), f[1], updateTarget_o);
          checkValue($sformatf("line %0d update type", lineNo), f[2], updateCtrlType_o);
          checkValue($sformatf("line %0d update taken", lineNo), f[3], updateTaken_o);
        end else if (kind == "ready") begin
          code = $fscanf(fd, "%h", f[0]);
          @(posedge clk);
          #1;
          readyMode = f[0][1:0];
          if (readyMode != 2'd2) outReady_i = f[0][0];
        end else if (kind == "status") begin
          code = $fscanf(fd, "%h", f[0]);
          #1;
          checkValue($sformatf("line %0d inReady", lineNo), f[0], inReady_o);
        end else if (kind == "idle") begin
          code = $fscanf(fd, "%h", f[0]);
          repeat (f[0]) @(posedge clk);
        end else if (kind == "drain") begin
          drainDecode();
        end else if (kind == "flush") begin
          @(posedge clk);
          #1;
          flush_i = 1'b1;
          @(posedge clk);
          #1;
          flush_i = 1'b0;
        end else begin
          $display("unknown vector kind at line %0d", lineNo);
          $display("TEST FAILED");
          $fatal(1, "bad vector file");
        end
      end
    end
    $fclose(fd);
    drainDecode();
    repeat (2) @(posedge clk);
    $display("TEST PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== design/fetchStage2Top.sv ====
/*
  fetch stage 2 with its output latch toward decode
  an accepted bundle reaches outValid_o one cycle after the accepting edge
*/
`timescale 1ns/1ps
`default_nettype none
`include "fetch_consts.svh"

module fetchStage2Top (
  input  logic                                          clk,
  input  logic                                          reset_i,
  input  logic                                          flush_i,
  input  logic                                          inValid_i,
  input  logic [`SIZE_PC-1:0]                           pc_i,
  input  logic [`FETCH_WIDTH-1:0][`SIZE_INSTRUCTION-1:0] bundle_i,
  input  logic [`FETCH_WIDTH-1:0]                       btbHit_i,
  input  logic [`FETCH_WIDTH-1:0]                       prediction_i,
  input  logic [`FETCH_WIDTH-1:0][`SIZE_PC-1:0]         btbTarget_i,
  input  logic [`SIZE_PC-1:0]                           rasTarget_i,
  output logic                                          inReady_o,
  output logic                                          recoverId_o,
  output logic [`SIZE_PC-1:0]                           targetId_o,
  output logic                                          returnId_o,
  output logic                                          callId_o,
  output logic [`SIZE_PC-1:0]                           callPcId_o,
  input  logic                                          outReady_i,
  output logic                                          outValid_o,
  output logic [`FETCH_WIDTH-1:0]                       slotValid_o,
  output logic [`FETCH_WIDTH-1:0][`SIZE_INSTRUCTION-1:0] slotInstr_o,
  output logic [`FETCH_WIDTH-1:0][`SIZE_PC-1:0]         slotPc_o,
  output logic [`FETCH_WIDTH-1:0][`SIZE_PC-1:0]         slotTarget_o,
  output logic [`FETCH_WIDTH-1:0][`SIZE_CTI_LOG-1:0]    slotTag_o,
  output logic [`FETCH_WIDTH-1:0]                       slotPred_o,
  input  logic                                          resolveValid_i,
  input  logic [`SIZE_CTI_LOG-1:0]                      resolveTag_i,
  input  logic [`SIZE_PC-1:0]                           resolveTarget_i,
  input  logic                                          resolveTaken_i,
  input  logic                                          commitValid_i,
  output logic                                          updateEn_o,
  output logic [`SIZE_PC-1:0]                           updatePc_o,
  output logic [`SIZE_PC-1:0]                           updateTarget_o,
  output fetchPkg::ctrlType_t                           updateCtrlType_o,
  output logic                                          updateTaken_o
);

  logic                                           latchReady;
  logic [`FETCH_WIDTH-1:0]                        s2Valid;
  logic [`FETCH_WIDTH-1:0][`SIZE_INSTRUCTION-1:0] s2Instr;
  logic [`FETCH_WIDTH-1:0][`SIZE_PC-1:0]          s2Pc;
  logic [`FETCH_WIDTH-1:0][`SIZE_PC-1:0]          s2Target;
  logic [`FETCH_WIDTH-1:0][`SIZE_CTI_LOG-1:0]     s2Tag;
  logic [`FETCH_WIDTH-1:0]                        s2Pred;

  fetchStage2 fetchStage2Inst (
    .clk              (clk),
    .reset_i          (reset_i),
    .flush_i          (flush_i),
    .inValid_i        (inValid_i),
    .pc_i             (pc_i),
    .bundle_i         (bundle_i),
    .btbHit_i         (btbHit_i),
    .prediction_i     (prediction_i),
    .btbTarget_i      (btbTarget_i),
    .rasTarget_i      (rasTarget_i),
    .latchReady_i     (latchReady),
    .inReady_o        (inReady_o),
    .recoverId_o      (recoverId_o),
    .targetId_o       (targetId_o),
    .returnId_o       (returnId_o),
    .callId_o         (callId_o),
    .callPcId_o       (callPcId_o),
    .slotValid_o      (s2Valid),
    .slotInstr_o      (s2Instr),
    .slotPc_o         (s2Pc),
    .slotTarget_o     (s2Target),
    .slotTag_o        (s2Tag),
    .slotPred_o       (s2Pred),
    .resolveValid_i   (resolveValid_i),
    .resolveTag_i     (resolveTag_i),
    .resolveTarget_i  (resolveTarget_i),
    .resolveTaken_i   (resolveTaken_i),
    .commitValid_i    (commitValid_i),
    .updateEn_o       (updateEn_o),
    .updatePc_o       (updatePc_o),
    .updateTarget_o   (updateTarget_o),
    .updateCtrlType_o (updateCtrlType_o),
    .updateTaken_o    (updateTaken_o)
  );

  bundleLatch bundleLatchInst (
    .clk          (clk),
    .reset_i      (reset_i),
    .flush_i      (flush_i),
    .inValid_i    (inValid_i),
    .slotValid_i  (s2Valid),
    .slotInstr_i  (s2Instr),
    .slotPc_i     (s2Pc),
    .slotTarget_i (s2Target),
    .slotTag_i    (s2Tag),
    .slotPred_i   (s2Pred),
    .outReady_i   (outReady_i),
    .ready_o      (latchReady),
    .outValid_o   (outValid_o),
    .slotValid_o  (slotValid_o),
    .slotInstr_o  (slotInstr_o),
    .slotPc_o     (slotPc_o),
    .slotTarget_o (slotTarget_o),
    .slotTag_o    (slotTag_o),
    .slotPred_o   (slotPred_o)
  );

endmodule

`default_nettype wire

// ==== design/bundleLatch.sv ====
/*
  one-entry valid/ready register between fetch stage 2 and decode
  a bundle with no valid slot is never stored
*/
`timescale 1ns/1ps
`default_nettype none
`include "fetch_consts.svh"

module bundleLatch (
  input  logic                                          clk,
  input  logic                                          reset_i,
  input  logic                                          flush_i,
  input  logic                                          inValid_i,
  input  logic [`FETCH_WIDTH-1:0]                       slotValid_i,
  input  logic [`FETCH_WIDTH-1:0][`SIZE_INSTRUCTION-1:0] slotInstr_i,
  input  logic [`FETCH_WIDTH-1:0][`SIZE_PC-1:0]         slotPc_i,
  input  logic [`FETCH_WIDTH-1:0][`SIZE_PC-1:0]         slotTarget_i,
  input  logic [`FETCH_WIDTH-1:0][`SIZE_CTI_LOG-1:0]    slotTag_i,
  input  logic [`FETCH_WIDTH-1:0]                       slotPred_i,
  input  logic                                          outReady_i,
  output logic                                          ready_o,
  output logic                                          outValid_o,
  output logic [`FETCH_WIDTH-1:0]                       slotValid_o,
  output logic [`FETCH_WIDTH-1:0][`SIZE_INSTRUCTION-1:0] slotInstr_o,
  output logic [`FETCH_WIDTH-1:0][`SIZE_PC-1:0]         slotPc_o,
  output logic [`FETCH_WIDTH-1:0][`SIZE_PC-1:0]         slotTarget_o,
  output logic [`FETCH_WIDTH-1:0][`SIZE_CTI_LOG-1:0]    slotTag_o,
  output logic [`FETCH_WIDTH-1:0]                       slotPred_o
);

  logic load;

  // room when empty or when decode drains the entry this cycle
  assign ready_o = ~outValid_o | outReady_i;
  assign load    = inValid_i & ready_o & (|slotValid_i);

  always_ff @(posedge clk) begin
    if (reset_i || flush_i) begin
      outValid_o <= 1'b0;
    end else if (load) begin
      outValid_o <= 1'b1;
    end else if (outReady_i) begin
      outValid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      slotValid_o  <= slotValid_i;
      slotInstr_o  <= slotInstr_i;
      slotPc_o     <= slotPc_i;
      slotTarget_o <= slotTarget_i;
      slotTag_o    <= slotTag_i;
      slotPred_o   <= slotPred_i;
    end
  end

endmodule

`default_nettype wire

// ==== design/fetchStage2.sv ====
/*
  pre-decode, BTB check and bundle cut for one four-wide fetch bundle
  everything from the bundle inputs to the packets and the redirect is combinational
  redirect flags are only meaningful for a bundle accepted in the same cycle
*/
`timescale 1ns/1ps
`default_nettype none
`include "fetch_consts.svh"

module fetchStage2 (
  input  logic                                          clk,
  input  logic                                          reset_i,
  input  logic                                          flush_i,
  input  logic                                          inValid_i,
  input  logic [`SIZE_PC-1:0]                           pc_i,
  input  logic [`FETCH_WIDTH-1:0][`SIZE_INSTRUCTION-1:0] bundle_i,
  input  logic [`FETCH_WIDTH-1:0]                       btbHit_i,
  input  logic [`FETCH_WIDTH-1:0]                       prediction_i,
  input  logic [`FETCH_WIDTH-1:0][`SIZE_PC-1:0]         btbTarget_i,
  input  logic [`SIZE_PC-1:0]                           rasTarget_i,
  input  logic                                          latchReady_i,
  output logic                                          inReady_o,
  output logic                                          recoverId_o,
  output logic [`SIZE_PC-1:0]                           targetId_o,
  output logic                                          returnId_o,
  output logic                                          callId_o,
  output logic [`SIZE_PC-1:0]                           callPcId_o,
  output logic [`FETCH_WIDTH-1:0]                       slotValid_o,
  output logic [`FETCH_WIDTH-1:0][`SIZE_INSTRUCTION-1:0] slotInstr_o,
  output logic [`FETCH_WIDTH-1:0][`SIZE_PC-1:0]         slotPc_o,
  output logic [`FETCH_WIDTH-1:0][`SIZE_PC-1:0]         slotTarget_o,
  output logic [`FETCH_WIDTH-1:0][`SIZE_CTI_LOG-1:0]    slotTag_o,
  output logic [`FETCH_WIDTH-1:0]                       slotPred_o,
  input  logic                                          resolveValid_i,
  input  logic [`SIZE_CTI_LOG-1:0]                      resolveTag_i,
  input  logic [`SIZE_PC-1:0]                           resolveTarget_i,
  input  logic                                          resolveTaken_i,
  input  logic                                          commitValid_i,
  output logic                                          updateEn_o,
  output logic [`SIZE_PC-1:0]                           updatePc_o,
  output logic [`SIZE_PC-1:0]                           updateTarget_o,
  output fetchPkg::ctrlType_t                           updateCtrlType_o,
  output logic                                          updateTaken_o
);

  import fetchPkg::*;

  localparam int slotBits = $clog2(`FETCH_WIDTH);

  logic      [`FETCH_WIDTH-1:0][`SIZE_PC-1:0] slotPc;
  logic      [`FETCH_WIDTH-1:0][`SIZE_PC-1:0] decTarget;
  ctrlType_t [`FETCH_WIDTH-1:0]               ctrlType;
  logic      [`FETCH_WIDTH-1:0]               isCtrl;
  logic      [`FETCH_WIDTH-1:0]               takenCtrl;
  logic      [`FETCH_WIDTH-1:0]               keep;
  logic      [`FETCH_WIDTH-1:0]               allocVector;
  logic      [`SIZE_CTI_LOG-1:0]              tailTag;
  logic      [`SIZE_CTI_LOG-1:0]              rank;
  logic      [slotBits-1:0]                   firstSlot;
  logic                                       anyTaken;
  logic                                       full;
  logic                                       fire;
  logic                                       recover;

  for (genvar s = 0; s < `FETCH_WIDTH; s++) begin : genSlot
    assign slotPc[s] = pc_i + `SIZE_PC'(s * `INST_BYTES);

    preDecode preDecodeInst (
      .pc_i          (slotPc[s]),
      .instruction_i (bundle_i[s]),
      .isCtrl_o      (isCtrl[s]),
      .ctrlType_o    (ctrlType[s]),
      .target_o      (decTarget[s])
    );

    // only conditional branches can fall through
    assign takenCtrl[s] = isCtrl[s] & ((ctrlType[s] != CT_BRANCH) | prediction_i[s]);

    // a BTB hit is trusted, a miss falls back on the decoded target
    assign slotTarget_o[s] = btbHit_i[s] ? btbTarget_i[s] :
                             (ctrlType[s] == CT_RETURN) ? rasTarget_i : decTarget[s];
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // cut the bundle after the first taken control transfer
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    keep      = '0;
    anyTaken  = 1'b0;
    firstSlot = '0;
    for (int i = 0; i < `FETCH_WIDTH; i++) begin
      if (!anyTaken) begin
        keep[i] = 1'b1;
        if (takenCtrl[i]) begin
          anyTaken  = 1'b1;
          firstSlot = slotBits'(i);
        end
      end
    end
  end

  assign allocVector = keep & isCtrl;

  // tags follow the tail in slot order among the allocated slots
  always_comb begin
    rank = '0;
    for (int i = 0; i < `FETCH_WIDTH; i++) begin
      slotTag_o[i] = tailTag + rank;
      rank         = rank + {{(`SIZE_CTI_LOG-1){1'b0}}, allocVector[i]};
    end
  end

  assign inReady_o = ~full & latchReady_i & ~flush_i;
  assign fire      = inValid_i & inReady_o;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // redirect toward fetch 1 when the BTB missed the taken slot
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign recover     = anyTaken & ~btbHit_i[firstSlot];
  assign recoverId_o = recover & fire;
  assign returnId_o  = recoverId_o & (ctrlType[firstSlot] == CT_RETURN);
  assign callId_o    = recoverId_o & (ctrlType[firstSlot] == CT_CALL);
  assign targetId_o  = (ctrlType[firstSlot] == CT_RETURN) ? rasTarget_i : decTarget[firstSlot];
  assign callPcId_o  = slotPc[firstSlot];

  // with no room in the queue the bundle presents no valid slots
  assign slotValid_o = keep & {`FETCH_WIDTH{~full}};
  assign slotInstr_o = bundle_i;
  assign slotPc_o    = slotPc;
  assign slotPred_o  = takenCtrl;

  ctiQueue ctiQueueInst (
    .clk              (clk),
    .reset_i          (reset_i),
    .flush_i          (flush_i),
    .allocate_i       (fire),
    .allocVector_i    (allocVector),
    .slotPc_i         (slotPc),
    .slotCtrlType_i   (ctrlType),
    .slotPred_i       (takenCtrl),
    .tailTag_o        (tailTag),
    .full_o           (full),
    .resolveValid_i   (resolveValid_i),
    .resolveTag_i     (resolveTag_i),
    .resolveTarget_i  (resolveTarget_i),
    .resolveTaken_i   (resolveTaken_i),
    .commitValid_i    (commitValid_i),
    .updateEn_o       (updateEn_o),
    .updatePc_o       (updatePc_o),
    .updateTarget_o   (updateTarget_o),
    .updateCtrlType_o (updateCtrlType_o),
    .updateTaken_o    (updateTaken_o)
  );

endmodule

`default_nettype wire

// ==== design/ctiQueue.sv ====
/*
  circular queue of in-flight control-transfer instructions
  the caller allocates only while full_o is low and resolves only allocated tags
  flush drops every uncommitted entry, the commit in the same cycle still retires
*/
`timescale 1ns/1ps
`default_nettype none
`include "fetch_consts.svh"

module ctiQueue (
  input  logic                                       clk,
  input  logic                                       reset_i,
  input  logic                                       flush_i,
  input  logic                                       allocate_i,
  input  logic [`FETCH_WIDTH-1:0]                    allocVector_i,
  input  logic [`FETCH_WIDTH-1:0][`SIZE_PC-1:0]      slotPc_i,
  input  fetchPkg::ctrlType_t [`FETCH_WIDTH-1:0]     slotCtrlType_i,
  input  logic [`FETCH_WIDTH-1:0]                    slotPred_i,
  output logic [`SIZE_CTI_LOG-1:0]                   tailTag_o,
  output logic                                       full_o,
  input  logic                                       resolveValid_i,
  input  logic [`SIZE_CTI_LOG-1:0]                   resolveTag_i,
  input  logic [`SIZE_PC-1:0]                        resolveTarget_i,
  input  logic                                       resolveTaken_i,
  input  logic                                       commitValid_i,
  output logic                                       updateEn_o,
  output logic [`SIZE_PC-1:0]                        updatePc_o,
  output logic [`SIZE_PC-1:0]                        updateTarget_o,
  output fetchPkg::ctrlType_t                        updateCtrlType_o,
  output logic                                       updateTaken_o
);

  import fetchPkg::*;

  // more than this many live entries leaves no room for a whole bundle
  localparam logic [`SIZE_CTI_LOG:0] fullLimit = `CTI_DEPTH - `FETCH_WIDTH;

  logic      [`SIZE_PC-1:0]      pcMem     [`CTI_DEPTH];
  logic      [`SIZE_PC-1:0]      targetMem [`CTI_DEPTH];
  ctrlType_t                     typeMem   [`CTI_DEPTH];
  logic                          dirMem    [`CTI_DEPTH];

  logic [`SIZE_CTI_LOG-1:0]  head;
  logic [`SIZE_CTI_LOG-1:0]  headNext;
  logic [`SIZE_CTI_LOG-1:0]  tail;
  logic [`SIZE_CTI_LOG:0]    count;
  logic [`SIZE_CTI_LOG:0]    allocCnt;
  logic [`SIZE_CTI_LOG-1:0]  allocIdx  [`FETCH_WIDTH];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // allocation slots, packed in slot order from the tail
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    allocCnt = '0;
    for (int i = 0; i < `FETCH_WIDTH; i++) begin
      allocIdx[i] = tail + allocCnt[`SIZE_CTI_LOG-1:0];
      allocCnt    = allocCnt + {{`SIZE_CTI_LOG{1'b0}}, allocVector_i[i]};
    end
  end

  assign headNext  = commitValid_i ? head + 1'b1 : head;
  assign tailTag_o = tail;
  assign full_o    = (count > fullLimit);

  always_ff @(posedge clk) begin
    if (reset_i) begin
      head       <= '0;
      tail       <= '0;
      count      <= '0;
      updateEn_o <= 1'b0;
    end else begin
      head       <= headNext;
      updateEn_o <= commitValid_i;
      if (flush_i) begin
        // tags restart right after the last committed entry
        tail  <= headNext;
        count <= '0;
      end else begin
        if (allocate_i) begin
          tail <= tail + allocCnt[`SIZE_CTI_LOG-1:0];
        end
        count <= count + (allocate_i ? allocCnt : '0)
               - {{`SIZE_CTI_LOG{1'b0}}, commitValid_i};
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // entry storage
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk) begin
    if (allocate_i) begin
      for (int i = 0; i < `FETCH_WIDTH; i++) begin
        if (allocVector_i[i]) begin
          pcMem[allocIdx[i]]   <= slotPc_i[i];
          typeMem[allocIdx[i]] <= slotCtrlType_i[i];
          dirMem[allocIdx[i]]  <= slotPred_i[i];
        end
      end
    end
    // execute has the final word on direction and target
    if (resolveValid_i) begin
      targetMem[resolveTag_i] <= resolveTarget_i;
      dirMem[resolveTag_i]    <= resolveTaken_i;
    end
  end

  // predictor update record, valid the cycle after the commit edge
  always_ff @(posedge clk) begin
    if (commitValid_i) begin
      updatePc_o       <= pcMem[head];
      updateTarget_o   <= targetMem[head];
      updateCtrlType_o <= typeMem[head];
      updateTaken_o    <= dirMem[head];
    end
  end

endmodule

`default_nettype wire

// ==== design/preDecode.sv ====
/*
  pre-decodes one instruction slot
  direct target is pc plus the sign-extended 16-bit offset in words
  returns carry no target here, the return stack supplies it
*/
`timescale 1ns/1ps
`default_nettype none
`include "fetch_consts.svh"

module preDecode (
  input  logic [`SIZE_PC-1:0]          pc_i,
  input  logic [`SIZE_INSTRUCTION-1:0] instruction_i,
  output logic                         isCtrl_o,
  output fetchPkg::ctrlType_t          ctrlType_o,
  output logic [`SIZE_PC-1:0]          target_o
);

  import fetchPkg::*;

  opcode_t                   opcode;
  logic    [15:0]            offset;
  logic    [`SIZE_PC-1:0]    offsetBytes;

  assign opcode = opcode_t'(instruction_i[`SIZE_INSTRUCTION-1 -: 6]);
  assign offset = instruction_i[15:0];

  // word offset turned into a byte offset
  assign offsetBytes = {{(`SIZE_PC-18){offset[15]}}, offset, 2'b00};

  always_comb begin
    isCtrl_o   = 1'b1;
    ctrlType_o = CT_JUMP;
    case (opcode)
      OP_BRANCH: ctrlType_o = CT_BRANCH;
      OP_JUMP:   ctrlType_o = CT_JUMP;
      OP_CALL:   ctrlType_o = CT_CALL;
      OP_RETURN: ctrlType_o = CT_RETURN;
      default:   isCtrl_o = 1'b0;
    endcase
  end

  assign target_o = (opcode == OP_RETURN) ? '0 : pc_i + offsetBytes;

endmodule

`default_nettype wire

// ==== design/fetchPkg.sv ====
/*
  opcode and control-type encodings of the simplified 32-bit instruction set
  the opcode sits in bits 31 to 26 of every instruction
*/
`default_nettype none

package fetchPkg;

  typedef enum logic [5:0] {
    OP_ALU    = 6'h00,
    OP_LOAD   = 6'h01,
    OP_STORE  = 6'h02,
    OP_BRANCH = 6'h10,
    OP_JUMP   = 6'h11,
    OP_CALL   = 6'h12,
    OP_RETURN = 6'h13
  } opcode_t;

  // same encoding as the predictor update port expects
  typedef enum logic [1:0] {
    CT_RETURN = 2'd0,
    CT_CALL   = 2'd1,
    CT_JUMP   = 2'd2,
    CT_BRANCH = 2'd3
  } ctrlType_t;

endpackage

`default_nettype wire

// ==== design/fetch_consts.svh ====
/*
  widths and depths shared by the fetch stage 2 design
  CTI_DEPTH must be a power of two equal to 2**SIZE_CTI_LOG and larger than FETCH_WIDTH
*/
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

// datapath widths
`define SIZE_PC           32
`define SIZE_INSTRUCTION  32

// bundle shape
`define FETCH_WIDTH       4
`define INST_BYTES        4

// control-transfer queue
`define CTI_DEPTH         8
`define SIZE_CTI_LOG      3

`endif
